//--- run.sh
#!/bin/sh
# Build and run the rtcMenu testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module rtcMenuTb -f src.f -o rtcMenuSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/rtcMenuSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
exit 0

//--- src.f
+incdir+verilog
verilog/fieldPkg.sv
verilog/menuPkg.sv
verilog/fieldIf.sv
verilog/buttonConditioner.sv
verilog/menuControl.sv
verilog/timeField.sv
verilog/fieldScanner.sv
verilog/rtcMenu.sv
test/rtcMenuTb.sv

//--- test/rtcMenuTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "menu_settings.svh"

module rtcMenuTb;

	localparam int MAX_ROWS = 128;
	localparam int RANDOM_ROWS = 24;
	// Button bits in the order up, down, left, right, center
	localparam logic [4:0] UP = 5'b10000;
	localparam logic [4:0] DOWN = 5'b01000;
	localparam logic [4:0] LEFT = 5'b00100;
	localparam logic [4:0] RIGHT = 5'b00010;
	localparam logic [4:0] CENTER = 5'b00001;
	// Longest gap between two scans with slack
	localparam int SCAN_TIMEOUT = `MENU_WAIT_CYCLES + 40;
	// Field limits in decimal for sec min hour day month year weekday
	localparam int LO_LIMIT [1:7] = '{0, 0, 0, 1, 1, 0, 1};
	localparam int HI_LIMIT [1:7] = '{59, 59, 23, 31, 12, 99, 7};

	logic CLK = 1'b0;
	logic RST;
	logic rtcReady;
	logic btnUp;
	logic btnDown;
	logic btnLeft;
	logic btnRight;
	logic btnCenter;
	wire scanValid;
	wire [2:0] scanAddr;
	wire [7:0] scanData;
	wire [2:0] editPtr;

	// Stimulus table with row 0 as the state right after reset
	logic [4:0] rowButtons [MAX_ROWS];
	logic rowEarly [MAX_ROWS];
	logic [2:0] rowPtr [MAX_ROWS];
	logic [7:0] rowFields [MAX_ROWS][1:7];
	int rowCount;
	logic tableBuilt;

	// Reference model state
	int modelVal [1:7];
	int modelPtr;

	logic [31:0] lfsr;
	int errors;
	int checks;

	rtcMenu i_rtcMenu (
		.CLK(CLK),
		.RST(RST),
		.rtcReady(rtcReady),
		.btnUp(btnUp),
		.btnDown(btnDown),
		.btnLeft(btnLeft),
		.btnRight(btnRight),
		.btnCenter(btnCenter),
		.scanValid(scanValid),
		.scanAddr(scanAddr),
		.scanData(scanData),
		.editPtr(editPtr)
	);

	initial
	begin
		forever #5 CLK = ~CLK;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		// Galois form with taps 32 22 2 1
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	function automatic logic nextRandomBit();
		logic bitOut;
		bitOut = lfsr[0];
		lfsr = lfsrStep(lfsr);
		return bitOut;
	endfunction

	function automatic logic [7:0] toBcd(input int v);
		return 8'((v / 10) * 16 + (v % 10));
	endfunction

	task automatic checkValue(input string name, input logic [7:0] got,
		input logic [7:0] expected);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, got, expected);
		end
	endtask

	// One edit step of the model
	task automatic modelEdit(input logic [4:0] b);
		logic up;
		logic down;
		logic left;
		logic right;
		logic center;
		int f;
		{up, down, left, right, center} = b;
		// Strobes hit the old pointer
		f = modelPtr;
		if (up && !down)
			modelVal[f] = (modelVal[f] == HI_LIMIT[f]) ? LO_LIMIT[f] : modelVal[f] + 1;
		else if (down && !up)
			modelVal[f] = (modelVal[f] == LO_LIMIT[f]) ? HI_LIMIT[f] : modelVal[f] - 1;
		if (center)
			modelPtr = 1;
		else if (left && !right)
			modelPtr = (modelPtr == 7) ? 1 : modelPtr + 1;
		else if (right && !left)
			modelPtr = (modelPtr == 1) ? 7 : modelPtr - 1;
	endtask

	task automatic addRow(input logic [4:0] b, input logic early);
		int k;
		if (rowCount != 0)
			modelEdit(b);
		rowButtons[rowCount] = b;
		rowEarly[rowCount] = early;
		rowPtr[rowCount] = 3'(modelPtr);
		for (k = 1; k <= `MENU_FIELD_COUNT; k++)
			rowFields[rowCount][k] = toBcd(modelVal[k]);
		rowCount++;
	endtask

	task automatic buildTable();
		int k;
		int r;
		logic [4:0] b;
		logic early;
		for (k = 1; k <= `MENU_FIELD_COUNT; k++)
			modelVal[k] = LO_LIMIT[k];
		modelPtr = 1;
		addRow(5'b0, 1'b0);
		// Up on second, left, up on minute, down wraps hour
		addRow(UP, 1'b0);
		addRow(LEFT, 1'b0);
		addRow(UP, 1'b0);
		addRow(LEFT, 1'b0);
		addRow(DOWN, 1'b0);
		// Center, wrap to weekday, down wraps it
		addRow(CENTER, 1'b0);
		addRow(RIGHT, 1'b0);
		addRow(DOWN, 1'b0);
		addRow(LEFT, 1'b0);
		addRow(RIGHT, 1'b0);
		// Center beats right and opposing pairs cancel
		addRow(CENTER | RIGHT, 1'b0);
		addRow(UP | DOWN, 1'b0);
		// Presses made during the scan
		addRow(LEFT | RIGHT, 1'b1);
		addRow(LEFT, 1'b1);
		// Month through 12 and back to 1
		repeat (3) addRow(LEFT, 1'b0);
		repeat (12) addRow(UP, 1'b0);
		// Minute through 59 and back to 0
		repeat (3) addRow(RIGHT, 1'b0);
		repeat (59) addRow(UP, 1'b0);
		for (r = 0; r < RANDOM_ROWS; r++)
		begin
			for (k = 4; k >= 0; k--)
				b[k] = nextRandomBit();
			early = nextRandomBit();
			addRow(b, early);
		end
	endtask

	// Holds the buttons for three cycles from a falling edge
	task automatic pressButtons(input logic [4:0] b);
		{btnUp, btnDown, btnLeft, btnRight, btnCenter} = b;
		repeat (3) @(negedge CLK);
		{btnUp, btnDown, btnLeft, btnRight, btnCenter} = 5'b0;
	endtask

	task automatic waitForScan(input int row, output logic found);
		int n;
		found = 1'b0;
		n = 0;
		while (!found && n < SCAN_TIMEOUT)
		begin
			@(negedge CLK);
			if (scanValid === 1'b1)
				found = 1'b1;
			n++;
		end
		if (!found)
		begin
			errors++;
			$display("Error at %0d ns: no scan started within %0d cycles for row %0d",
				$time, SCAN_TIMEOUT, row);
		end
	endtask

	// Seven beats with addresses 1 to 7 back to back
	task automatic checkScan(input int row);
		int k;
		for (k = 1; k <= `MENU_FIELD_COUNT; k++)
		begin
			// Beat 1 is where the scan was found
			if (k > 1)
				checkValue($sformatf("scanValid beat %0d row %0d", k, row),
					8'(scanValid), 8'h01);
			checkValue($sformatf("scanAddr row %0d", row), 8'(scanAddr), 8'(k));
			checkValue($sformatf("scanData[%0d] row %0d", k, row), scanData, rowFields[row][k]);
			checkValue($sformatf("editPtr row %0d", row), 8'(editPtr), 8'(rowPtr[row]));
			@(negedge CLK);
		end
		checkValue($sformatf("scanValid after beat 7 row %0d", row), 8'(scanValid), 8'h00);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////
	initial
	begin : mainSequence
		logic found;
		int i;
		RST = 1'b1;
		rtcReady = 1'b0;
		btnUp = 1'b0;
		btnDown = 1'b0;
		btnLeft = 1'b0;
		btnRight = 1'b0;
		btnCenter = 1'b0;
		errors = 0;
		checks = 0;
		rowCount = 0;
		lfsr = 32'ha2e4;
		tableBuilt = 1'b0;
		buildTable();
		tableBuilt = 1'b1;

		repeat (16) @(negedge CLK);
		RST = 1'b0;

		// No scan before ready
		repeat (20)
		begin
			@(negedge CLK);
			checkValue("scanValid before ready", 8'(scanValid), 8'h00);
			checkValue("editPtr before ready", 8'(editPtr), 8'h01);
		end
		rtcReady = 1'b1;

		// Each scan shows the edit made with the previous row's buttons
		for (i = 0; i < rowCount; i++)
		begin
			waitForScan(i, found);
			if (!found)
				break;
			if (i + 1 < rowCount && rowEarly[i + 1])
			begin
				fork
					checkScan(i);
					pressButtons(rowButtons[i + 1]);
				join
			end
			else
			begin
				checkScan(i);
				// Lands in the wait step
				if (i + 1 < rowCount)
					pressButtons(rowButtons[i + 1]);
			end
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////
	initial
	begin : watchdog
		int limit;
		wait (tableBuilt === 1'b1);
		// Reset, idle check, one scan period per row, margin
		limit = 16 + 20 + rowCount * (`MENU_WAIT_CYCLES + 40) + 200;
		repeat (limit) @(posedge CLK);
		$display("Error: watchdog expired after %0d cycles, the run did not finish", limit);
		$display("Checks: %0d, errors: %0d", checks, errors + 1);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/buttonConditioner.sv
`timescale 1ns/10ps
`default_nettype none

module buttonConditioner (
	input wire CLK,
	input wire RST,
	input wire btnUp,
	input wire btnDown,
	input wire btnLeft,
	input wire btnRight,
	input wire btnCenter,
	input wire take,
	output menuPkg::buttonSet pending
);

	// Raw levels gathered into one set
	menuPkg::buttonSet raw;
	// Two synchronizer stages and the edge detector history
	menuPkg::buttonSet syncA;
	menuPkg::buttonSet syncB;
	menuPkg::buttonSet last;
	// Rising edges, one cycle wide
	menuPkg::buttonSet rise;

	assign raw.up = btnUp;
	assign raw.down = btnDown;
	assign raw.left = btnLeft;
	assign raw.right = btnRight;
	assign raw.center = btnCenter;

	assign rise = syncB & ~last;

	//////////////////////////////////////////////////
	// Sync, edge detect, sticky flags
	//////////////////////////////////////////////////
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			syncA <= '0;
			syncB <= '0;
			last <= '0;
			pending <= '0;
		end
		else
		begin
			syncA <= raw;
			syncB <= syncA;
			last <= syncB;
			// Take clears, a new edge in the same cycle survives
			if (take)
				pending <= rise;
			else
				pending <= pending | rise;
		end
	end

endmodule

`default_nettype wire

//--- verilog/fieldIf.sv
`timescale 1ns/10ps
`default_nettype none

`include "menu_settings.svh"

interface fieldIf;

	// Edit pointer, selects the field that the strobes act on
	fieldPkg::fieldAddr fieldSel;

	// One-cycle edit strobes
	logic incr;
	logic decr;

	// Register bank, one element per field, indexed by address
	fieldPkg::fieldValue [`MENU_FIELD_COUNT:1] values;

	// Controller side
	modport editor (output fieldSel, output incr, output decr);

	// Counter side, each counter drives only its own element
	modport field (input fieldSel, input incr, input decr, output values);

	// Scanner side
	modport reader (input values);

endinterface

`default_nettype wire

//--- verilog/fieldPkg.sv
`default_nettype none

`include "menu_settings.svh"

package fieldPkg;

	// Field address, 1 to 7, 0 never used
	typedef logic [2:0] fieldAddr;

	// First and last addresses of the scan and the pointer
	localparam fieldAddr FIRST_ADDR = 3'd1;
	localparam fieldAddr LAST_ADDR = 3'(`MENU_FIELD_COUNT);

	// Two BCD digits, tens in the upper nibble
	typedef struct packed {
		logic [`MENU_BCD_WIDTH-1:0] tens;
		logic [`MENU_BCD_WIDTH-1:0] ones;
	} bcdDigits;

	// Same byte seen raw or as digits
	typedef union packed {
		logic [2*`MENU_BCD_WIDTH-1:0] raw;
		bcdDigits digits;
	} fieldValue;

	////////////////////////////////////////////////////
	// Limit tables, indexed by address
	// sec, min, hour, day, month, year, weekday
	////////////////////////////////////////////////////
	localparam logic [0:`MENU_FIELD_COUNT][7:0] FIELD_MIN = '{
		8'h00, 8'h00, 8'h00, 8'h00, 8'h01, 8'h01, 8'h00, 8'h01
	};

	localparam logic [0:`MENU_FIELD_COUNT][7:0] FIELD_MAX = '{
		8'h00, 8'h59, 8'h59, 8'h23, 8'h31, 8'h12, 8'h99, 8'h07
	};

endpackage

`default_nettype wire

//--- verilog/fieldScanner.sv
`timescale 1ns/10ps
`default_nettype none

module fieldScanner (
	input wire CLK,
	input wire RST,
	input wire scanStart,
	output logic scanDone,
	fieldIf.reader bus,
	output logic scanValid,
	output fieldPkg::fieldAddr scanAddr,
	output logic [7:0] scanData
);

	// Load a new address this cycle
	logic load;
	fieldPkg::fieldAddr nextAddr;

	// Restart wins over stepping
	assign nextAddr = scanStart ? fieldPkg::FIRST_ADDR : scanAddr + 1'b1;
	assign load = scanStart | (scanValid & (scanAddr != fieldPkg::LAST_ADDR));

	//////////////////////////////////////////////////
	// Address counter and done pulse
	//////////////////////////////////////////////////
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			scanValid <= 1'b0;
			scanAddr <= fieldPkg::FIRST_ADDR;
			scanDone <= 1'b0;
		end
		else
		begin
			scanValid <= load;
			// Done rides along with the last valid cycle
			scanDone <= load & (nextAddr == fieldPkg::LAST_ADDR);
			if (load)
				scanAddr <= nextAddr;
		end
	end

	// Registered read port, byte view of the field
	always_ff @(posedge CLK)
	begin
		if (load)
			scanData <= bus.values[nextAddr].raw;
	end

endmodule

`default_nettype wire

//--- verilog/menuControl.sv
`timescale 1ns/10ps
`default_nettype none

module menuControl (
	input wire CLK,
	input wire RST,
	input wire rtcReady,
	input wire menuPkg::buttonSet pending,
	output wire take,
	output logic scanStart,
	input wire scanDone,
	fieldIf.editor edit,
	output fieldPkg::fieldAddr editPtr
);

	menuPkg::menuState state;
	menuPkg::waitCount waitCnt;

	// Edit cycle flag
	logic inEdit;
	// Opposing pairs cancel
	logic upOnly;
	logic downOnly;
	logic leftOnly;
	logic rightOnly;
	// Pointer value after this edit
	fieldPkg::fieldAddr nextPtr;

	assign inEdit = (state == menuPkg::menuEdit);

	assign upOnly = pending.up & ~pending.down;
	assign downOnly = pending.down & ~pending.up;
	assign leftOnly = pending.left & ~pending.right;
	assign rightOnly = pending.right & ~pending.left;

	//////////////////////////////////////////////////
	// Edit cycle outputs
	//////////////////////////////////////////////////
	// Flags are consumed in the same cycle they are used
	assign take = inEdit;
	assign edit.incr = inEdit & upOnly;
	assign edit.decr = inEdit & downOnly;
	// Strobes act on the old pointer
	assign edit.fieldSel = editPtr;

	// Center wins over left and right
	always_comb
	begin
		nextPtr = editPtr;
		if (pending.center)
			nextPtr = fieldPkg::FIRST_ADDR;
		else if (leftOnly)
		begin
			// Wrap 7 to 1
			if (editPtr == fieldPkg::LAST_ADDR)
				nextPtr = fieldPkg::FIRST_ADDR;
			else
				nextPtr = editPtr + 1'b1;
		end
		else if (rightOnly)
		begin
			// Wrap 1 to 7
			if (editPtr == fieldPkg::FIRST_ADDR)
				nextPtr = fieldPkg::LAST_ADDR;
			else
				nextPtr = editPtr - 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Scan, wait, edit sequencing
	//////////////////////////////////////////////////
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			state <= menuPkg::menuIdle;
			waitCnt <= '0;
			editPtr <= fieldPkg::FIRST_ADDR;
			scanStart <= 1'b0;
		end
		else
		begin
			// Start pulse, one cycle
			scanStart <= 1'b0;
			case (state)
				menuPkg::menuIdle:
				begin
					// Ready only matters here
					if (rtcReady)
					begin
						state <= menuPkg::menuScan;
						scanStart <= 1'b1;
					end
				end
				menuPkg::menuScan:
				begin
					if (scanDone)
					begin
						state <= menuPkg::menuWait;
						waitCnt <= '0;
					end
				end
				menuPkg::menuWait:
				begin
					if (waitCnt == menuPkg::WAIT_LAST)
						state <= menuPkg::menuEdit;
					else
						waitCnt <= waitCnt + 1'b1;
				end
				menuPkg::menuEdit:
				begin
					// Fields update on this same edge, next scan sees them
					editPtr <= nextPtr;
					state <= menuPkg::menuScan;
					scanStart <= 1'b1;
				end
				default:
					state <= menuPkg::menuIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/menuPkg.sv
`default_nettype none

`include "menu_settings.svh"

package menuPkg;

	// Controller states
	// Idle until ready, then scan, wait, edit forever
	typedef enum logic [1:0] {
		menuIdle,
		menuScan,
		menuWait,
		menuEdit
	} menuState;

	// Pending presses, one flag per button
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic center;
	} buttonSet;

	// Wait counter and its terminal value
	typedef logic [$clog2(`MENU_WAIT_CYCLES)-1:0] waitCount;
	localparam waitCount WAIT_LAST = waitCount'(`MENU_WAIT_CYCLES - 1);

endpackage

`default_nettype wire

//--- verilog/menu_settings.svh
`ifndef MENU_SETTINGS_SVH
`define MENU_SETTINGS_SVH

// Number of time fields in the register bank
`define MENU_FIELD_COUNT 7

// Cycles spent idle between a scan and the next edit
`define MENU_WAIT_CYCLES 100

// Width of one BCD digit
`define MENU_BCD_WIDTH 4

`endif

//--- verilog/rtcMenu.sv
`timescale 1ns/10ps
`default_nettype none

`include "menu_settings.svh"

module rtcMenu (
	input wire CLK,
	input wire RST,
	input wire rtcReady,
	input wire btnUp,
	input wire btnDown,
	input wire btnLeft,
	input wire btnRight,
	input wire btnCenter,
	output wire scanValid,
	output wire fieldPkg::fieldAddr scanAddr,
	output wire [7:0] scanData,
	output wire fieldPkg::fieldAddr editPtr
);

	// Conditioner to controller
	wire menuPkg::buttonSet pending;
	wire take;
	// Controller to scanner
	wire scanStart;
	wire scanDone;

	// Edit strobes and register bank
	fieldIf bus ();

	buttonConditioner i_buttonConditioner (
		.CLK(CLK),
		.RST(RST),
		.btnUp(btnUp),
		.btnDown(btnDown),
		.btnLeft(btnLeft),
		.btnRight(btnRight),
		.btnCenter(btnCenter),
		.take(take),
		.pending(pending)
	);

	menuControl i_menuControl (
		.CLK(CLK),
		.RST(RST),
		.rtcReady(rtcReady),
		.pending(pending),
		.take(take),
		.scanStart(scanStart),
		.scanDone(scanDone),
		.edit(bus.editor),
		.editPtr(editPtr)
	);

	//////////////////////////////////////////////////
	// One counter per field, limits from the tables
	//////////////////////////////////////////////////
	for (genvar g = 1; g <= `MENU_FIELD_COUNT; g++)
	begin : genField
		timeField #(
			.fieldIndex(fieldPkg::fieldAddr'(g)),
			.minValue(fieldPkg::FIELD_MIN[g]),
			.maxValue(fieldPkg::FIELD_MAX[g])
		) i_timeField (
			.CLK(CLK),
			.RST(RST),
			.bus(bus.field)
		);
	end

	fieldScanner i_fieldScanner (
		.CLK(CLK),
		.RST(RST),
		.scanStart(scanStart),
		.scanDone(scanDone),
		.bus(bus.reader),
		.scanValid(scanValid),
		.scanAddr(scanAddr),
		.scanData(scanData)
	);

endmodule

`default_nettype wire

//--- verilog/timeField.sv
`timescale 1ns/10ps
`default_nettype none

module timeField #(
	parameter fieldPkg::fieldAddr fieldIndex = 3'd1,
	parameter logic [7:0] minValue = 8'h00,
	parameter logic [7:0] maxValue = 8'h59
) (
	input wire CLK,
	input wire RST,
	fieldIf.field bus
);

	// Current BCD value and the value after a strobe
	fieldPkg::fieldValue value;
	fieldPkg::fieldValue stepped;
	// Strobes address this field
	logic hit;

	assign hit = (bus.fieldSel == fieldIndex);

	//////////////////////////////////////////////////
	// BCD step with wrap at the limits
	//////////////////////////////////////////////////
	always_comb
	begin
		stepped = value;
		if (bus.incr)
		begin
			if (value.raw == maxValue)
				stepped.raw = minValue;
			else if (value.digits.ones == 4'd9)
			begin
				// Carry into tens
				stepped.digits.ones = 4'd0;
				stepped.digits.tens = value.digits.tens + 1'b1;
			end
			else
				stepped.digits.ones = value.digits.ones + 1'b1;
		end
		else if (bus.decr)
		begin
			if (value.raw == minValue)
				stepped.raw = maxValue;
			else if (value.digits.ones == 4'd0)
			begin
				// Borrow from tens
				stepped.digits.ones = 4'd9;
				stepped.digits.tens = value.digits.tens - 1'b1;
			end
			else
				stepped.digits.ones = value.digits.ones - 1'b1;
		end
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			value.raw <= minValue;
		else if (hit)
			value <= stepped;
	end

	// Own slot in the bank
	assign bus.values[fieldIndex] = value;

endmodule

`default_nettype wire
